// File: Bender.yml
package:
  name: cache

sources:
  - logic/cache_pkg.sv
  - logic/cache_sram.sv
  - logic/cache_replace.sv
  - logic/cache_be_ctrl.sv
  - logic/cache_ctrl.sv
  - logic/cache_top.sv
  - target: simulation
    files:
      - verification/cache_tb.sv

// File: filelist.f
logic/cache_pkg.sv
logic/cache_sram.sv
logic/cache_replace.sv
logic/cache_be_ctrl.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verification/cache_tb.sv

// File: logic/cache_be_ctrl.sv
module cache_be_ctrl (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           start_i,
   input  cache_pkg::be_op_e              op_i,
   input  logic [cache_pkg::FE_ADDR_W-1:0] addr_i,
   input  logic [cache_pkg::NBYTES-1:0]    wstrb_i,
   input  logic [cache_pkg::DATA_W-1:0]    wdata_i,
   output cache_pkg::be_req_t             be_req_o,
   input  cache_pkg::be_resp_t            be_resp_i,
   output logic                           fill_we_o,
   output logic [cache_pkg::NWORDS_W-1:0]  fill_word_o,
   output logic [cache_pkg::DATA_W-1:0]    fill_data_o,
   output logic                           done_o
);

   import cache_pkg::*;

   be_state_e            state_q;
   logic [FE_ADDR_W-1:0] addr_q;
   logic [NBYTES-1:0]    wstrb_q;
   logic [DATA_W-1:0]    wdata_q;
   logic [NWORDS_W-1:0]  req_cnt_q;
   logic [NWORDS_W-1:0]  rsp_cnt_q;
   logic                 done_q;

   always_comb begin
      be_req_o.avalid = (state_q == BE_RD_REQ) | (state_q == BE_WR);
      be_req_o.wstrb  = (state_q == BE_WR) ? wstrb_q : '0;
      be_req_o.wdata  = wdata_q;
      // refill walks the line from word 0
      if (state_q == BE_WR) begin
         be_req_o.addr = addr_q;
      end else begin
         be_req_o.addr = {addr_q[FE_ADDR_W-1:NWORDS_W+BOFF_W], req_cnt_q, {BOFF_W{1'b0}}};
      end
   end

   // returned words go straight into the data RAM
   assign fill_we_o   = be_resp_i.rvalid & ((state_q == BE_RD_REQ) | (state_q == BE_RD_WAIT));
   assign fill_word_o = rsp_cnt_q;
   assign fill_data_o = be_resp_i.rdata;
   assign done_o      = done_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= BE_IDLE;
         req_cnt_q <= '0;
         rsp_cnt_q <= '0;
         done_q    <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (fill_we_o) begin
            rsp_cnt_q <= rsp_cnt_q + 1'b1;
         end
         case (state_q)
            BE_IDLE: begin
               if (start_i) begin
                  req_cnt_q <= '0;
                  rsp_cnt_q <= '0;
                  state_q   <= (op_i == OP_WRITE) ? BE_WR : BE_RD_REQ;
               end
            end
            BE_RD_REQ: begin
               if (be_resp_i.ready) begin
                  req_cnt_q <= req_cnt_q + 1'b1;
                  if (req_cnt_q == '1) begin
                     state_q <= BE_RD_WAIT;
                  end
               end
            end
            BE_RD_WAIT: begin
               if (be_resp_i.rvalid && rsp_cnt_q == '1) begin
                  state_q <= BE_IDLE;
                  done_q  <= 1'b1;
               end
            end
            BE_WR: begin
               if (be_resp_i.ready) begin
                  state_q <= BE_IDLE;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= BE_IDLE;
         endcase
      end
   end

   // operands captured at start
   always_ff @(posedge clk_i) begin
      if (state_q == BE_IDLE && start_i) begin
         addr_q  <= addr_i;
         wstrb_q <= wstrb_i;
         wdata_q <= wdata_i;
      end
   end

   a_req_held: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      be_req_o.avalid && !be_resp_i.ready |=>
         be_req_o.avalid && $stable(be_req_o.addr) && $stable(be_req_o.wdata)
   );

endmodule

// File: logic/cache_ctrl.sv
module cache_ctrl (
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  cache_pkg::fe_req_t                fe_req_i,
   output cache_pkg::fe_resp_t               fe_resp_o,
   input  logic                              invalidate_i,
   output logic                              wr_hit_o,
   output logic                              wr_miss_o,
   output logic                              rd_hit_o,
   output logic                              rd_miss_o,
   output logic                              data_mem_en_o,
   output logic [cache_pkg::DMEM_NB-1:0]      data_mem_we_o,
   output logic [cache_pkg::DMEM_DEPTH_W-1:0] data_mem_addr_o,
   output logic [cache_pkg::DMEM_W-1:0]       data_mem_d_o,
   input  logic [cache_pkg::DMEM_W-1:0]       data_mem_d_i,
   output logic                              tag_mem_en_o,
   output logic [cache_pkg::NWAYS-1:0]        tag_mem_we_o,
   output logic [cache_pkg::NLINES_W-1:0]     tag_mem_addr_o,
   output logic [cache_pkg::TAGMEM_W-1:0]     tag_mem_d_o,
   input  logic [cache_pkg::TAGMEM_W-1:0]     tag_mem_d_i,
   input  logic [cache_pkg::NWAYS_W-1:0]      victim_i,
   output logic                              refill_done_o,
   output logic                              be_start_o,
   output cache_pkg::be_op_e                 be_op_o,
   output logic [cache_pkg::FE_ADDR_W-1:0]    be_addr_o,
   output logic [cache_pkg::NBYTES-1:0]       be_wstrb_o,
   output logic [cache_pkg::DATA_W-1:0]       be_wdata_o,
   input  logic                              fill_we_i,
   input  logic [cache_pkg::NWORDS_W-1:0]     fill_word_i,
   input  logic [cache_pkg::DATA_W-1:0]       fill_data_i,
   input  logic                              be_done_i
);

   import cache_pkg::*;

   ctrl_state_e                  state_q;
   ctrl_state_e                  state_d;
   fe_req_t                      req_q;
   logic [NLINES-1:0][NWAYS-1:0] valid_q;
   logic [NWAYS_W-1:0]           victim_q;
   logic                         reread_q;

   logic               lookup;
   logic               rd_r;
   logic               wr_r;
   logic               hit;
   logic               ready;
   logic               accept;
   logic               fill_done;
   logic [NWAYS-1:0]   way_hit;
   logic [NWAYS_W-1:0] hit_way;
   logic [NWAYS_W-1:0] rd_way;

   assign lookup = (state_q == ST_LOOKUP);
   assign rd_r   = req_q.avalid & ~|req_q.wstrb;
   assign wr_r   = req_q.avalid & |req_q.wstrb;

   // tag compare, gated by the valid bits of the line
   always_comb begin
      for (int w = 0; w < NWAYS; w++) begin
         way_hit[w] = valid_q[req_q.addr.index][w] &
                      (tag_mem_d_i[w*TAG_W +: TAG_W] == req_q.addr.tag);
      end
   end

   always_comb begin
      hit_way = '0;
      for (int w = 0; w < NWAYS; w++) begin
         if (way_hit[w]) begin
            hit_way = NWAYS_W'(w);
         end
      end
   end

   assign hit       = |way_hit;
   assign rd_hit_o  = lookup & rd_r & hit;
   assign rd_miss_o = lookup & rd_r & ~hit;
   assign wr_hit_o  = lookup & wr_r & hit;
   assign wr_miss_o = lookup & wr_r & ~hit;

   // a read hit keeps the pipe open, write-through frees it on done
   assign ready     = (state_q == ST_IDLE) | rd_hit_o | ((state_q == ST_WTHRU) & be_done_i);
   assign accept    = fe_req_i.avalid & ready;
   assign fill_done = (state_q == ST_REFILL) & be_done_i;

   assign refill_done_o = fill_done;

   // after a refill the requested word comes from the victim way
   assign rd_way           = reread_q ? victim_q : hit_way;
   assign fe_resp_o.ready  = ready;
   assign fe_resp_o.rvalid = rd_hit_o | reread_q;
   assign fe_resp_o.rdata  = data_mem_d_i[rd_way*DATA_W +: DATA_W];

   always_comb begin
      data_mem_en_o = accept | wr_hit_o | fill_we_i | fill_done;
      data_mem_we_o = '0;
      data_mem_d_o  = {NWAYS{fill_data_i}};
      if (wr_hit_o) begin
         data_mem_we_o = DMEM_NB'(req_q.wstrb) << (hit_way * NBYTES);
         data_mem_d_o  = {NWAYS{req_q.wdata}};
      end else if (fill_we_i) begin
         data_mem_we_o = DMEM_NB'({NBYTES{1'b1}}) << (victim_q * NBYTES);
      end
      if (accept) begin
         data_mem_addr_o = {fe_req_i.addr.index, fe_req_i.addr.word};
      end else if (fill_we_i) begin
         data_mem_addr_o = {req_q.addr.index, fill_word_i};
      end else begin
         data_mem_addr_o = {req_q.addr.index, req_q.addr.word};
      end
   end

   // tag written once the whole line is in
   assign tag_mem_en_o   = accept | fill_done;
   assign tag_mem_we_o   = {NWAYS{fill_done}} & (NWAYS'(1) << victim_q);
   assign tag_mem_addr_o = accept ? fe_req_i.addr.index : req_q.addr.index;
   assign tag_mem_d_o    = {NWAYS{req_q.addr.tag}};

   assign be_start_o = rd_miss_o | (lookup & wr_r);
   assign be_op_o    = wr_r ? OP_WRITE : OP_REFILL;
   assign be_addr_o  = {req_q.addr.tag, req_q.addr.index, req_q.addr.word, {BOFF_W{1'b0}}};
   assign be_wstrb_o = req_q.wstrb;
   assign be_wdata_o = req_q.wdata;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               state_d = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (wr_r) begin
               state_d = ST_WTHRU;
            end else if (rd_miss_o) begin
               state_d = ST_REFILL;
            end else if (!accept) begin
               state_d = ST_IDLE;
            end
         end
         ST_REFILL: begin
            if (be_done_i) begin
               state_d = ST_IDLE;
            end
         end
         ST_WTHRU: begin
            if (be_done_i) begin
               state_d = accept ? ST_LOOKUP : ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= ST_IDLE;
         reread_q <= 1'b0;
         valid_q  <= '0;
      end else begin
         state_q  <= state_d;
         reread_q <= fill_done;
         if (invalidate_i && (state_q == ST_IDLE || lookup)) begin
            valid_q <= '0;
         end else if (fill_done) begin
            valid_q[req_q.addr.index][victim_q] <= 1'b1;
         end
      end
   end

   // request and victim way held for the lookup and refill
   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= fe_req_i;
      end
      if (rd_miss_o) begin
         victim_q <= victim_i;
      end
   end

   // a tag is only written on a miss, so no two valid ways match
   a_way_hit_onehot: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      lookup |-> $onehot0(way_hit)
   );

   a_no_rvalid_after_write: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      accept && |fe_req_i.wstrb |=> !fe_resp_o.rvalid
   );

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

   // front-end address and word geometry
   localparam int FE_ADDR_W = 16;
   localparam int DATA_W    = 32;
   localparam int NBYTES    = DATA_W / 8;
   localparam int BOFF_W    = $clog2(NBYTES);

   // two ways, 16 lines of 4 words each
   localparam int NWAYS    = 2;
   localparam int NWAYS_W  = $clog2(NWAYS);
   localparam int NLINES_W = 4;
   localparam int NLINES   = 2 ** NLINES_W;
   localparam int NWORDS_W = 2;
   localparam int NWORDS   = 2 ** NWORDS_W;
   localparam int TAG_W    = FE_ADDR_W - NLINES_W - NWORDS_W - BOFF_W;

   // data RAM holds the same word of every way side by side
   localparam int DMEM_W       = NWAYS * DATA_W;
   localparam int DMEM_NB      = NWAYS * NBYTES;
   localparam int DMEM_DEPTH_W = NLINES_W + NWORDS_W;

   // tag RAM holds one tag per way, one byte lane each
   localparam int TAGMEM_W = NWAYS * TAG_W;

   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [NLINES_W-1:0] index;
      logic [NWORDS_W-1:0] word;
      logic [BOFF_W-1:0]   boff;
   } fe_addr_t;

   // zero wstrb means read
   typedef struct packed {
      logic              avalid;
      fe_addr_t          addr;
      logic [NBYTES-1:0] wstrb;
      logic [DATA_W-1:0] wdata;
   } fe_req_t;

   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
   } fe_resp_t;

   typedef struct packed {
      logic                 avalid;
      logic [FE_ADDR_W-1:0] addr;
      logic [NBYTES-1:0]    wstrb;
      logic [DATA_W-1:0]    wdata;
   } be_req_t;

   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
   } be_resp_t;

   typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_REFILL, ST_WTHRU} ctrl_state_e;

   typedef enum logic [1:0] {BE_IDLE, BE_RD_REQ, BE_RD_WAIT, BE_WR} be_state_e;

   typedef enum logic {OP_REFILL, OP_WRITE} be_op_e;

endpackage

// File: logic/cache_replace.sv
module cache_replace (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic [cache_pkg::NLINES_W-1:0] index_i,
   input  logic                          advance_i,
   output logic [cache_pkg::NWAYS_W-1:0]  victim_o
);

   import cache_pkg::*;

   // one round-robin pointer per line
   logic [NLINES-1:0][NWAYS_W-1:0] ptr_q;

   assign victim_o = ptr_q[index_i];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ptr_q <= '0;
      end else if (advance_i) begin
         // wrap back to way 0 after the last way
         if (ptr_q[index_i] == NWAYS_W'(NWAYS - 1)) begin
            ptr_q[index_i] <= '0;
         end else begin
            ptr_q[index_i] <= ptr_q[index_i] + 1'b1;
         end
      end
   end

   // a refill takes several cycles, so done never repeats back to back
   a_advance_single: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      advance_i |=> !advance_i
   );

endmodule

// File: logic/cache_sram.sv
module cache_sram #(
   parameter int DATA_W  = 32,
   parameter int DEPTH_W = 4
) (
   input  logic                  clk_i,
   input  logic                  en_i,
   input  logic [DATA_W/8-1:0]   we_i,
   input  logic [DEPTH_W-1:0]    addr_i,
   input  logic [DATA_W-1:0]     d_i,
   output logic [DATA_W-1:0]     d_o
);

   localparam int NLANES = DATA_W / 8;

   logic [DATA_W-1:0] mem [2**DEPTH_W];

   // read-first, read data valid one cycle after en_i
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         for (int b = 0; b < NLANES; b++) begin
            if (we_i[b]) begin
               mem[addr_i][b*8 +: 8] <= d_i[b*8 +: 8];
            end
         end
         d_o <= mem[addr_i];
      end
   end

endmodule

// File: logic/cache_top.sv
module cache_top (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  cache_pkg::fe_req_t  fe_req_i,
   output cache_pkg::fe_resp_t fe_resp_o,
   input  logic                invalidate_i,
   output logic                wr_hit_o,
   output logic                wr_miss_o,
   output logic                rd_hit_o,
   output logic                rd_miss_o,
   output cache_pkg::be_req_t  be_req_o,
   input  cache_pkg::be_resp_t be_resp_i
);

   import cache_pkg::*;

   // data and tag RAM ports
   logic                    data_mem_en;
   logic [DMEM_NB-1:0]      data_mem_we;
   logic [DMEM_DEPTH_W-1:0] data_mem_addr;
   logic [DMEM_W-1:0]       data_mem_wdata;
   logic [DMEM_W-1:0]       data_mem_rdata;
   logic                    tag_mem_en;
   logic [NWAYS-1:0]        tag_mem_we;
   logic [NLINES_W-1:0]     tag_mem_addr;
   logic [TAGMEM_W-1:0]     tag_mem_wdata;
   logic [TAGMEM_W-1:0]     tag_mem_rdata;

   logic [NWAYS_W-1:0] victim;
   logic               refill_done;

   // controller to back-end sequencer
   logic                 be_start;
   be_op_e               be_op;
   logic [FE_ADDR_W-1:0] be_addr;
   logic [NBYTES-1:0]    be_wstrb;
   logic [DATA_W-1:0]    be_wdata;
   logic                 fill_we;
   logic [NWORDS_W-1:0]  fill_word;
   logic [DATA_W-1:0]    fill_data;
   logic                 be_done;

   cache_ctrl ctrl (
      .clk_i, .rst_n_i, .fe_req_i, .fe_resp_o, .invalidate_i,
      .wr_hit_o, .wr_miss_o, .rd_hit_o, .rd_miss_o,
      .data_mem_en_o(data_mem_en), .data_mem_we_o(data_mem_we),
      .data_mem_addr_o(data_mem_addr), .data_mem_d_o(data_mem_wdata),
      .data_mem_d_i(data_mem_rdata),
      .tag_mem_en_o(tag_mem_en), .tag_mem_we_o(tag_mem_we),
      .tag_mem_addr_o(tag_mem_addr), .tag_mem_d_o(tag_mem_wdata),
      .tag_mem_d_i(tag_mem_rdata),
      .victim_i(victim), .refill_done_o(refill_done),
      .be_start_o(be_start), .be_op_o(be_op), .be_addr_o(be_addr),
      .be_wstrb_o(be_wstrb), .be_wdata_o(be_wdata),
      .fill_we_i(fill_we), .fill_word_i(fill_word), .fill_data_i(fill_data),
      .be_done_i(be_done)
   );

   cache_sram #(.DATA_W(DMEM_W), .DEPTH_W(DMEM_DEPTH_W)) data_ram (
      .clk_i, .en_i(data_mem_en), .we_i(data_mem_we), .addr_i(data_mem_addr),
      .d_i(data_mem_wdata), .d_o(data_mem_rdata)
   );

   cache_sram #(.DATA_W(TAGMEM_W), .DEPTH_W(NLINES_W)) tag_ram (
      .clk_i, .en_i(tag_mem_en), .we_i(tag_mem_we), .addr_i(tag_mem_addr),
      .d_i(tag_mem_wdata), .d_o(tag_mem_rdata)
   );

   // tag RAM address is the index of the line being looked up or refilled
   cache_replace replace (
      .clk_i, .rst_n_i, .index_i(tag_mem_addr), .advance_i(refill_done), .victim_o(victim)
   );

   cache_be_ctrl be_ctrl (
      .clk_i, .rst_n_i, .start_i(be_start), .op_i(be_op), .addr_i(be_addr),
      .wstrb_i(be_wstrb), .wdata_i(be_wdata), .be_req_o, .be_resp_i,
      .fill_we_o(fill_we), .fill_word_o(fill_word), .fill_data_o(fill_data),
      .done_o(be_done)
   );

endmodule

// File: verification/cache_golden.txt
# columns: test op addr wstrb wdata exp_rdata exp_hit, all hex except exp_hit
# wr checks exp_rdata against main memory, rd2 pairs with the read on the next line
cold_miss       rd  1234 0 00000000 a5001234 0
cold_hit_same   rd  1234 0 00000000 a5001234 1
cold_hit_word   rd  1238 0 00000000 a5001238 1
cold_hit_first  rd  1230 0 00000000 a5001230 1
wr_hit          wr  1238 6 11223344 a5223338 1
wr_hit_read     rd  1238 0 00000000 a5223338 1
wr_hit_full     wr  123c f cafef00d cafef00d 1
wr_hit_full_rd  rd  123c 0 00000000 cafef00d 1
wr_miss         wr  4510 f 12345678 12345678 0
wr_miss_read    rd  4510 0 00000000 12345678 0
wr_miss_line    rd  4514 0 00000000 a5004514 1
wr_miss_part    wr  5520 1 000000ee a50055ee 0
wr_miss_part_rd rd  5520 0 00000000 a50055ee 0
rr_first        rd  1070 0 00000000 a5001070 0
rr_second       rd  2074 0 00000000 a5002074 0
rr_third        rd  3078 0 00000000 a5003078 0
rr_first_again  rd  1070 0 00000000 a5001070 0
rr_third_again  rd  3078 0 00000000 a5003078 1
inv_all         inv 0000 0 00000000 00000000 0
inv_read        rd  1238 0 00000000 a5223338 0
inv_refilled    rd  1234 0 00000000 a5001234 1
b2b_first       rd2 1230 0 00000000 a5001230 1
b2b_second      rd  123c 0 00000000 cafef00d 1

// File: verification/cache_tb.sv
module cache_tb;

   import cache_pkg::*;

   localparam int TIMEOUT   = 200;
   localparam int MEM_WORDS = 2 ** (FE_ADDR_W - BOFF_W);
   localparam logic [DATA_W-1:0] MEM_BASE = 32'hA500_0000;

   logic     clk = 1'b0;
   logic     rst_n;
   fe_req_t  fe_req;
   fe_resp_t fe_resp;
   logic     invalidate;
   logic     wr_hit;
   logic     wr_miss;
   logic     rd_hit;
   logic     rd_miss;
   be_req_t  be_req;
   be_resp_t be_resp;

   // main memory model
   logic [DATA_W-1:0]           mem [MEM_WORDS];
   logic [FE_ADDR_W-BOFF_W-1:0] widx;
   be_req_t                     be_req_s;
   int                          wait_cnt;
   integer                      seed = 32'he596;

   logic [DATA_W-1:0] rdata_q [$];
   bit                hit_q [$];
   bit                wr_q [$];
   int                errors = 0;
   int                tests = 0;
   int                failed = 0;

   always #20 clk = ~clk;

   cache_top cache_top_i (
      .clk_i(clk), .rst_n_i(rst_n), .fe_req_i(fe_req), .fe_resp_o(fe_resp),
      .invalidate_i(invalidate), .wr_hit_o(wr_hit), .wr_miss_o(wr_miss),
      .rd_hit_o(rd_hit), .rd_miss_o(rd_miss), .be_req_o(be_req), .be_resp_i(be_resp)
   );

   // each word starts as its byte address plus a base
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = MEM_BASE + DATA_W'(i * NBYTES);
      end
   end

   // back-end request sampled mid-cycle and acted on at the next rising edge
   always @(negedge clk) begin
      be_req_s = be_req;
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         be_resp <= '0;
         wait_cnt = 0;
      end else begin
         be_resp.ready  <= 1'b0;
         be_resp.rvalid <= 1'b0;
         widx = be_req_s.addr[FE_ADDR_W-1:BOFF_W];
         if (be_req_s.avalid && be_resp.ready) begin
            if (|be_req_s.wstrb) begin
               for (int b = 0; b < NBYTES; b++) begin
                  if (be_req_s.wstrb[b]) begin
                     mem[widx][b*8 +: 8] <= be_req_s.wdata[b*8 +: 8];
                  end
               end
            end else begin
               be_resp.rvalid <= 1'b1;
               be_resp.rdata  <= mem[widx];
            end
            wait_cnt = $random(seed) & 3;
         end else if (be_req_s.avalid) begin
            if (wait_cnt == 0) begin
               be_resp.ready <= 1'b1;
            end else begin
               wait_cnt--;
            end
         end
      end
   end

   // collect front-end responses and lookup pulses
   always @(negedge clk) begin
      if (rst_n && fe_resp.rvalid) begin
         rdata_q.push_back(fe_resp.rdata);
      end
      if (rst_n && (rd_hit || wr_hit)) begin
         hit_q.push_back(1'b1);
         wr_q.push_back(wr_hit);
      end
      if (rst_n && (rd_miss || wr_miss)) begin
         hit_q.push_back(1'b0);
         wr_q.push_back(wr_miss);
      end
   end

   task automatic compare_value(input string name, input string what,
                                input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] got);
      assert (got === exp) else begin
         $display("[ERROR] %0s: %0s expected %0h, actual %0h", name, what, exp, got);
         errors++;
      end
   endtask

   // returns just after the edge that accepts the request
   task automatic send_req(input logic [FE_ADDR_W-1:0] addr, input logic [NBYTES-1:0] wstrb,
                           input logic [DATA_W-1:0] wdata, output int waited);
      fe_req.avalid <= 1'b1;
      fe_req.addr   <= addr;
      fe_req.wstrb  <= wstrb;
      fe_req.wdata  <= wdata;
      waited = 0;
      @(negedge clk);
      while (!fe_resp.ready && waited < TIMEOUT) begin
         waited++;
         @(negedge clk);
      end
      if (!fe_resp.ready) begin
         $display("request to address %h was never accepted, wait timed out", addr);
         errors++;
      end
      @(posedge clk);
   endtask

   task automatic wait_responses(input int count);
      int cycles = 0;
      while (rdata_q.size() < count && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (rdata_q.size() < count) begin
         $display("read data did not come back, wait timed out");
         errors++;
      end
   endtask

   task automatic wait_write_done();
      int cycles = 0;
      @(negedge clk);
      while (!fe_resp.ready && cycles < TIMEOUT) begin
         cycles++;
         @(negedge clk);
      end
      if (!fe_resp.ready) begin
         $display("write-through never finished, wait timed out");
         errors++;
      end
      @(posedge clk);
   endtask

   // hit flag and read or write kind of one monitor pulse
   task automatic check_lookup(input string name, input int idx, input bit exp_wr,
                               input bit exp_hit);
      assert (hit_q.size() > idx) else begin
         $display("%0s: no hit or miss pulse was seen for the lookup", name);
         errors++;
      end
      if (hit_q.size() > idx) begin
         compare_value(name, "hit flag", exp_hit, hit_q[idx]);
         compare_value(name, "write monitor pulse", exp_wr, wr_q[idx]);
      end
   endtask

   task automatic check_response(input string name, input int idx,
                                 input logic [DATA_W-1:0] exp, input bit exp_hit);
      if (rdata_q.size() > idx) begin
         compare_value(name, "read data", exp, rdata_q[idx]);
      end
      check_lookup(name, idx, 1'b0, exp_hit);
   endtask

   task automatic run_read(input string name, input logic [FE_ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] exp, input bit exp_hit);
      int waited;
      rdata_q.delete();
      hit_q.delete();
      wr_q.delete();
      send_req(addr, '0, '0, waited);
      fe_req.avalid <= 1'b0;
      wait_responses(1);
      check_response(name, 0, exp, exp_hit);
   endtask

   task automatic run_write(input string name, input logic [FE_ADDR_W-1:0] addr,
                            input logic [NBYTES-1:0] wstrb, input logic [DATA_W-1:0] wdata,
                            input logic [DATA_W-1:0] exp, input bit exp_hit);
      int waited;
      rdata_q.delete();
      hit_q.delete();
      wr_q.delete();
      send_req(addr, wstrb, wdata, waited);
      fe_req.avalid <= 1'b0;
      fe_req.wstrb  <= '0;
      wait_write_done();
      check_lookup(name, 0, 1'b1, exp_hit);
      // written-through word as seen by main memory
      compare_value(name, "memory word", exp, mem[addr[FE_ADDR_W-1:BOFF_W]]);
      assert (rdata_q.size() == 0) else begin
         $display("%0s: a read response came back for a write", name);
         errors++;
      end
   endtask

   task automatic run_read_pair(input string name_a, input logic [FE_ADDR_W-1:0] addr_a,
                                input logic [DATA_W-1:0] exp_a, input bit hit_a,
                                input string name_b, input logic [FE_ADDR_W-1:0] addr_b,
                                input logic [DATA_W-1:0] exp_b, input bit hit_b);
      int waited;
      rdata_q.delete();
      hit_q.delete();
      wr_q.delete();
      send_req(addr_a, '0, '0, waited);
      send_req(addr_b, '0, '0, waited);
      fe_req.avalid <= 1'b0;
      assert (waited == 0) else begin
         $display("%0s: second read was held off while the first was answered", name_b);
         errors++;
      end
      wait_responses(2);
      check_response(name_a, 0, exp_a, hit_a);
      check_response(name_b, 1, exp_b, hit_b);
   endtask

   task automatic pulse_invalidate();
      invalidate <= 1'b1;
      @(posedge clk);
      invalidate <= 1'b0;
      @(posedge clk);
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests++;
      if (errors == errs_before) begin
         $display("test %0s passed", name);
      end else begin
         failed++;
         $display("test %0s failed", name);
      end
   endtask

   // skips comment lines and reads the next data line of the golden file
   function automatic bit next_entry(input int fd, output string name, output string op,
                                     output logic [FE_ADDR_W-1:0] addr,
                                     output logic [NBYTES-1:0] wstrb,
                                     output logic [DATA_W-1:0] wdata,
                                     output logic [DATA_W-1:0] exp, output int hit);
      int c;
      while ($fscanf(fd, "%s", name) == 1) begin
         if (name[0] != "#") begin
            return $fscanf(fd, "%s %h %h %h %h %d", op, addr, wstrb, wdata, exp, hit) == 6;
         end
         c = $fgetc(fd);
         while (c != 10 && c != -1) begin
            c = $fgetc(fd);
         end
      end
      return 1'b0;
   endfunction

   initial begin
      int                   fd;
      int                   errs_before;
      int                   hit;
      int                   hit_b;
      string                name;
      string                op;
      string                name_b;
      string                op_b;
      logic [FE_ADDR_W-1:0] addr;
      logic [FE_ADDR_W-1:0] addr_b;
      logic [NBYTES-1:0]    wstrb;
      logic [NBYTES-1:0]    wstrb_b;
      logic [DATA_W-1:0]    wdata;
      logic [DATA_W-1:0]    wdata_b;
      logic [DATA_W-1:0]    exp;
      logic [DATA_W-1:0]    exp_b;
      fe_req     = '0;
      be_resp    = '0;
      invalidate = 1'b0;
      rst_n      = 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      fd = $fopen("verification/cache_golden.txt", "r");
      if (fd == 0) begin
         $display("golden file verification/cache_golden.txt could not be opened");
         errors++;
      end else begin
         while (next_entry(fd, name, op, addr, wstrb, wdata, exp, hit)) begin
            errs_before = errors;
            if (op == "rd") begin
               run_read(name, addr, exp, hit != 0);
            end else if (op == "wr") begin
               run_write(name, addr, wstrb, wdata, exp, hit != 0);
            end else if (op == "inv") begin
               pulse_invalidate();
            end else if (op == "rd2") begin
               if (next_entry(fd, name_b, op_b, addr_b, wstrb_b, wdata_b, exp_b, hit_b)) begin
                  run_read_pair(name, addr, exp, hit != 0, name_b, addr_b, exp_b, hit_b != 0);
                  report_test(name_b, errs_before);
               end else begin
                  $display("%0s: golden file ends before the second read of the pair", name);
                  errors++;
               end
            end else begin
               $display("%0s: unknown operation %0s in the golden file", name, op);
               errors++;
            end
            report_test(name, errs_before);
         end
         $fclose(fd);
      end
      $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0 && tests > 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
